/* logic/wbh_defs.svh */
//--------------------------------------------------------------------
// wishbone host constants
// local space decode, register map and register reset values
//--------------------------------------------------------------------
`ifndef WBH_DEFS_SVH
`define WBH_DEFS_SVH

//--------------------------------------------------------------------
// address decode
//--------------------------------------------------------------------
`define WBH_LOCAL_BIT    23     // set = local register space
`define WBH_BANK_LSB     24     // bank select starts here on slave side

// register index field inside the byte address
`define WBH_REG_ADR_LSB  2
`define WBH_REG_ADR_MSB  3

//--------------------------------------------------------------------
// register map
//--------------------------------------------------------------------
`define WBH_REG_GLB      2'd0   // global control, resets + clock fields
`define WBH_REG_BANK     2'd1   // upper address byte for slave accesses
`define WBH_REG_CLK1     2'd2   // clock control word 1
`define WBH_REG_CLK2     2'd3   // clock control word 2

// bank select after reset
`define WBH_BANK_RST     8'h10

`endif

/* logic/wbh_bus_pkg.sv */
//--------------------------------------------------------------------
// wishbone bus types
// request and response bundles shared by masters, host and slave
//--------------------------------------------------------------------
package wbh_bus_pkg;

   //-----------------------------------------------------------------
   // master to slave
   //-----------------------------------------------------------------
   typedef struct packed
   {
      logic        cyc;       // bus cycle
      logic        stb;       // strobe, held until ack or err
      logic [31:0] adr;       // byte address
      logic        we;        // 1 write, 0 read
      logic [31:0] dat;       // write data
      logic [3:0]  sel;       // byte enables
   } wb_req_t;

   //-----------------------------------------------------------------
   // slave to master
   //-----------------------------------------------------------------
   // dat is only meaningful with ack on a read
   typedef struct packed
   {
      logic [31:0] dat;       // read data
      logic        ack;       // normal end of transfer
      logic        err;       // error end of transfer
   } wb_rsp_t;

endpackage

/* logic/wbh_reg_pkg.sv */
//--------------------------------------------------------------------
// wishbone host register types
// subsystem resets, global control word views and register index
//--------------------------------------------------------------------
package wbh_reg_pkg;

   // active low subsystem resets, wbd sits at bit 0
   typedef struct packed
   {
      logic bist;     // bit 7
      logic usb;
      logic i2cm;
      logic uart;
      logic sspim;
      logic qspim;
      logic cpu;
      logic wbd;      // bit 0
   } subsys_rst_t;

   //-----------------------------------------------------------------
   // global control word, field view, msb first
   //-----------------------------------------------------------------
   typedef struct packed
   {
      logic [3:0]  usb;     // [31:28] usb clock ctrl
      logic [3:0]  spare;   // [27:24]
      logic [3:0]  cpu;     // [23:20] cpu clock ctrl
      logic [7:0]  rtc;     // [19:12] rtc clock ctrl
      logic [2:0]  wb;      // [11:9]  wb clock ctrl
      logic        rsvd;    // [8]
      subsys_rst_t rst;     // [7:0]
   } glb_fields_t;

   // raw word for writes and readback, fields for the reset outputs
   typedef union packed
   {
      logic [31:0] raw;
      glb_fields_t f;
   } glb_ctrl_u;

   // word index within the local register space
   typedef logic [1:0] reg_idx_t;

endpackage

/* logic/wbh_arb.sv */
//--------------------------------------------------------------------
// two master arbiter, external port has priority
// grant is held until the granted strobe drops
//--------------------------------------------------------------------
`timescale 1ns/1ps

module wbh_arb
(
   input  logic                 wbm_clk_i,
   input  logic                 wbm_rst_n,
   input  wbh_bus_pkg::wb_req_t m0_req_i,    // external host
   input  wbh_bus_pkg::wb_req_t m1_req_i,    // auxiliary master
   input  wbh_bus_pkg::wb_rsp_t sel_rsp_i,
   output wbh_bus_pkg::wb_req_t sel_req_o,
   output wbh_bus_pkg::wb_rsp_t m0_rsp_o,
   output wbh_bus_pkg::wb_rsp_t m1_rsp_o
);
   import wbh_bus_pkg::*;

   logic    grant_q;     // 0 external, 1 auxiliary
   logic    grant_nxt;
   wb_req_t gnt_req;     // request of current owner

   // request mux on the registered grant
   always_comb
   begin
      if (grant_q)
         gnt_req = m1_req_i;
      else
         gnt_req = m0_req_i;
   end

   // owner keeps bus while stb high, otherwise re-arbitrate
   always_comb
   begin
      grant_nxt = grant_q;
      if (!gnt_req.stb)
      begin
         if (m0_req_i.stb)
            grant_nxt = 1'b0;      // external wins ties
         else if (m1_req_i.stb)
            grant_nxt = 1'b1;
      end
   end

   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
         grant_q <= 1'b0;
      else
         grant_q <= grant_nxt;
   end

   assign sel_req_o = gnt_req;

   // response only to the owner, the other one sees idle
   assign m0_rsp_o = grant_q ? '0 : sel_rsp_i;
   assign m1_rsp_o = grant_q ? sel_rsp_i : '0;

   a_grant_hold : assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      gnt_req.stb |=> $stable(grant_q))
      else $error("grant moved under an active strobe");

endmodule

/* logic/wbh_req_stage.sv */
//--------------------------------------------------------------------
// request stage, registers the strobe and splits local and remote
// accesses, then registers the response back to the master side
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "wbh_defs.svh"

module wbh_req_stage
(
   input  logic                  wbm_clk_i,
   input  logic                  wbm_rst_n,
   input  wbh_bus_pkg::wb_req_t  sel_req_i,
   input  logic [7:0]            bank_sel_i,
   input  logic [31:0]           reg_rdata_i,
   input  logic                  reg_ack_i,
   input  wbh_bus_pkg::wb_rsp_t  wbs_rsp_i,
   output wbh_bus_pkg::wb_rsp_t  sel_rsp_o,
   output logic                  reg_rd_o,
   output logic                  reg_wr_o,
   output wbh_reg_pkg::reg_idx_t reg_idx_o,
   output logic [31:0]           reg_wdata_o,
   output wbh_bus_pkg::wb_req_t  wbs_req_o
);
   import wbh_bus_pkg::*;
   import wbh_reg_pkg::*;

   logic        wb_req;       // internal request
   logic        local_hit;    // address in register space
   wb_rsp_t     rsp_nxt;      // selected response, unregistered
   logic        rsp_done;
   logic        ack_q;
   logic        err_q;
   logic [31:0] dat_q;

   assign local_hit = sel_req_i.adr[`WBH_LOCAL_BIT];

   //-----------------------------------------------------------------
   // local register side, strobes only
   //-----------------------------------------------------------------
   assign reg_rd_o    = wb_req & local_hit & ~sel_req_i.we;
   assign reg_wr_o    = wb_req & local_hit & sel_req_i.we;
   assign reg_idx_o   = reg_idx_t'(sel_req_i.adr[`WBH_REG_ADR_MSB:`WBH_REG_ADR_LSB]);
   assign reg_wdata_o = sel_req_i.dat;

   // remote side, bank select replaces the top address byte
   always_comb
   begin
      wbs_req_o     = sel_req_i;                       // we, dat, sel as is
      wbs_req_o.cyc = sel_req_i.cyc & ~local_hit;
      wbs_req_o.stb = wb_req & ~local_hit;
      wbs_req_o.adr = {bank_sel_i, sel_req_i.adr[`WBH_BANK_LSB-1:0]};
   end

   // response select, slave answers count only under its stb
   always_comb
   begin
      if (local_hit)
      begin
         rsp_nxt.dat = reg_rdata_i;
         rsp_nxt.ack = reg_ack_i;
         rsp_nxt.err = 1'b0;         // registers never fail
      end
      else
      begin
         rsp_nxt.dat = wbs_rsp_i.dat;
         rsp_nxt.ack = wbs_rsp_i.ack & wbs_req_o.stb;
         rsp_nxt.err = wbs_rsp_i.err & wbs_req_o.stb;
      end
   end

   assign rsp_done = rsp_nxt.ack | rsp_nxt.err;

   // request is blocked the cycle of a response and the one after
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         wb_req <= 1'b0;
         ack_q  <= 1'b0;
         err_q  <= 1'b0;
      end
      else
      begin
         wb_req <= sel_req_i.stb & ~rsp_done & ~(ack_q | err_q);
         ack_q  <= rsp_nxt.ack;
         err_q  <= rsp_nxt.err;
      end
   end

   always_ff @(posedge wbm_clk_i)
   begin
      if (rsp_nxt.ack)
         dat_q <= rsp_nxt.dat;       // keep last read data
   end

   assign sel_rsp_o = '{dat: dat_q, ack: ack_q, err: err_q};

   a_one_target : assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      !((reg_rd_o | reg_wr_o) && wbs_req_o.stb))
      else $error("register strobe and slave stb high together");

   a_stb_drop : assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      (wbs_req_o.stb && (wbs_rsp_i.ack || wbs_rsp_i.err)) |=> !wbs_req_o.stb)
      else $error("slave stb still high after slave response");

endmodule

/* logic/wbh_regs.sv */
//--------------------------------------------------------------------
// local control registers, global control, bank select and
// two clock control words, with registered read and single ack
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "wbh_defs.svh"

module wbh_regs
(
   input  logic                     wbm_clk_i,
   input  logic                     wbm_rst_n,
   input  logic                     reg_rd_i,
   input  logic                     reg_wr_i,
   input  wbh_reg_pkg::reg_idx_t    reg_idx_i,
   input  logic [31:0]              reg_wdata_i,
   output logic [31:0]              reg_rdata_o,
   output logic                     reg_ack_o,
   output logic [7:0]               bank_sel_o,
   output wbh_reg_pkg::subsys_rst_t subsys_rst_o,
   output logic [31:0]              cfg_clk_ctrl1_o,
   output logic [31:0]              cfg_clk_ctrl2_o
);
   import wbh_reg_pkg::*;

   glb_ctrl_u   glb_q;        // global control
   logic [7:0]  bank_q;       // bank select
   logic [31:0] clk1_q;
   logic [31:0] clk2_q;
   logic [31:0] rd_mux;
   logic        wr_en;

   // one write per access, the strobe outlives the ack by a cycle
   assign wr_en = reg_wr_i & ~reg_ack_o;

   //-----------------------------------------------------------------
   // register file
   //-----------------------------------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         glb_q.raw <= '0;              // all subsystems held in reset
         bank_q    <= `WBH_BANK_RST;
         clk1_q    <= '0;
         clk2_q    <= '0;
      end
      else if (wr_en)
      begin
         case (reg_idx_i)
            `WBH_REG_GLB  : glb_q.raw <= reg_wdata_i;
            `WBH_REG_BANK : bank_q    <= reg_wdata_i[7:0];   // low byte only
            `WBH_REG_CLK1 : clk1_q    <= reg_wdata_i;
            default       : clk2_q    <= reg_wdata_i;
         endcase
      end
   end

   // readback mux
   always_comb
   begin
      case (reg_idx_i)
         `WBH_REG_GLB  : rd_mux = glb_q.raw;
         `WBH_REG_BANK : rd_mux = {24'h0, bank_q};
         `WBH_REG_CLK1 : rd_mux = clk1_q;
         default       : rd_mux = clk2_q;
      endcase
   end

   // ack one cycle after the strobe, never back to back
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
         reg_ack_o <= 1'b0;
      else
         reg_ack_o <= (reg_rd_i | reg_wr_i) & ~reg_ack_o;
   end

   always_ff @(posedge wbm_clk_i)
   begin
      if (reg_rd_i & ~reg_ack_o)
         reg_rdata_o <= rd_mux;
   end

   assign bank_sel_o      = bank_q;
   assign subsys_rst_o    = glb_q.f.rst;    // clock fields only stored
   assign cfg_clk_ctrl1_o = clk1_q;
   assign cfg_clk_ctrl2_o = clk2_q;

   a_ack_single : assert property (@(posedge wbm_clk_i) disable iff (!wbm_rst_n)
      reg_ack_o |=> !reg_ack_o)
      else $error("register ack high two cycles running");

endmodule

/* logic/wb_host.sv */
//--------------------------------------------------------------------
// wishbone host top, two masters onto one slave plus local
// reset and clock control registers
//--------------------------------------------------------------------
`timescale 1ns/1ps

module wb_host
(
   input  logic                     wbm_clk_i,
   input  logic                     wbm_rst_n,
   input  wbh_bus_pkg::wb_req_t     wbm_req_i,      // external host
   input  wbh_bus_pkg::wb_req_t     aux_req_i,      // auxiliary master
   input  wbh_bus_pkg::wb_rsp_t     wbs_rsp_i,
   output wbh_bus_pkg::wb_rsp_t     wbm_rsp_o,
   output wbh_bus_pkg::wb_rsp_t     aux_rsp_o,
   output wbh_bus_pkg::wb_req_t     wbs_req_o,
   output wbh_reg_pkg::subsys_rst_t subsys_rst_o,
   output logic [31:0]              cfg_clk_ctrl1_o,
   output logic [31:0]              cfg_clk_ctrl2_o
);
   import wbh_bus_pkg::*;
   import wbh_reg_pkg::*;

   //-----------------------------------------------------------------
   // internal bus
   //-----------------------------------------------------------------
   wb_req_t     sel_req;      // granted request
   wb_rsp_t     sel_rsp;      // registered response
   logic        reg_rd;
   logic        reg_wr;
   reg_idx_t    reg_idx;
   logic [31:0] reg_wdata;
   logic [31:0] reg_rdata;
   logic        reg_ack;
   logic [7:0]  bank_sel;

   wbh_arb u_arb
   (
      .wbm_clk_i (wbm_clk_i),
      .wbm_rst_n (wbm_rst_n),
      .m0_req_i  (wbm_req_i),
      .m1_req_i  (aux_req_i),
      .sel_rsp_i (sel_rsp),
      .sel_req_o (sel_req),
      .m0_rsp_o  (wbm_rsp_o),
      .m1_rsp_o  (aux_rsp_o)
   );

   wbh_req_stage u_req
   (
      .wbm_clk_i   (wbm_clk_i),
      .wbm_rst_n   (wbm_rst_n),
      .sel_req_i   (sel_req),
      .bank_sel_i  (bank_sel),
      .reg_rdata_i (reg_rdata),
      .reg_ack_i   (reg_ack),
      .wbs_rsp_i   (wbs_rsp_i),
      .sel_rsp_o   (sel_rsp),
      .reg_rd_o    (reg_rd),
      .reg_wr_o    (reg_wr),
      .reg_idx_o   (reg_idx),
      .reg_wdata_o (reg_wdata),
      .wbs_req_o   (wbs_req_o)
   );

   wbh_regs u_regs
   (
      .wbm_clk_i       (wbm_clk_i),
      .wbm_rst_n       (wbm_rst_n),
      .reg_rd_i        (reg_rd),
      .reg_wr_i        (reg_wr),
      .reg_idx_i       (reg_idx),
      .reg_wdata_i     (reg_wdata),
      .reg_rdata_o     (reg_rdata),
      .reg_ack_o       (reg_ack),
      .bank_sel_o      (bank_sel),
      .subsys_rst_o    (subsys_rst_o),
      .cfg_clk_ctrl1_o (cfg_clk_ctrl1_o),
      .cfg_clk_ctrl2_o (cfg_clk_ctrl2_o)
   );

endmodule

/* tb/tb_wb_host.sv */
//----------------------------------------------------------------------
// wishbone host testbench, table driven accesses from both masters
// to the local registers and to a slave model with random wait
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "wbh_defs.svh"

module tb_wb_host;
   import wbh_bus_pkg::*;
   import wbh_reg_pkg::*;

   localparam int ACC_LIMIT = 24;            // cycles allowed per access

   logic          wbm_clk_i = 1'b0;
   logic          wbm_rst_n;
   wb_req_t       wbm_req_i;
   wb_req_t       aux_req_i;
   wb_rsp_t       wbs_rsp_i;
   wb_rsp_t       wbm_rsp_o;
   wb_rsp_t       aux_rsp_o;
   wb_req_t       wbs_req_o;
   subsys_rst_t   subsys_rst_o;
   logic [31:0]   cfg_clk_ctrl1_o;
   logic [31:0]   cfg_clk_ctrl2_o;

   integer        seed = 32'hfb86_03ab;
   int            n_cases = 0;
   int            pass_cnt = 0;
   int            fail_cnt = 0;
   logic          loaded = 1'b0;             // starts the watchdog

   reg [8*24-1:0] c_name [0:63];             // case table
   int            c_mst [0:63];              // 0 ext, 1 aux, 2 both
   reg [7:0]      c_op [0:63];               // r, w, e = read ending in err
   logic [31:0]   c_adr [0:63];
   logic [31:0]   c_dat [0:63];
   logic [31:0]   c_exp [0:63];

   logic          slv_busy = 1'b0;           // slave model state
   logic [31:0]   slv_wait;
   logic [31:0]   slv_adr;                   // last access seen by the slave
   logic [31:0]   slv_dat;
   logic [3:0]    slv_sel;
   logic          slv_we;

   wb_host dut (.*);

   always #4 wbm_clk_i = ~wbm_clk_i;         // 8 ns period

   //------------------------------------------------------------------
   // slave model, inverted address after 0 to 3 cycles, err on bank ee
   //------------------------------------------------------------------
   always @(posedge wbm_clk_i)
   begin
      wbs_rsp_i.ack <= 1'b0;
      wbs_rsp_i.err <= 1'b0;
      // new access only once the previous answer is gone
      if (wbm_rst_n && !slv_busy && wbs_req_o.cyc && wbs_req_o.stb &&
          !(wbs_rsp_i.ack || wbs_rsp_i.err))
      begin
         slv_busy = 1'b1;
         slv_wait = $random(seed) & 3;
      end
      if (slv_busy && slv_wait != 0)
         slv_wait = slv_wait - 1;            // back-pressure
      else if (slv_busy)
      begin
         slv_busy = 1'b0;
         slv_adr  = wbs_req_o.adr;
         slv_dat  = wbs_req_o.dat;
         slv_sel  = wbs_req_o.sel;
         slv_we   = wbs_req_o.we;
         if (wbs_req_o.adr[31:24] == 8'hee)
            wbs_rsp_i.err <= 1'b1;
         else
         begin
            wbs_rsp_i.ack <= 1'b1;
            wbs_rsp_i.dat <= ~wbs_req_o.adr;
         end
      end
   end

   // a master without stb must see a silent port
   always @(posedge wbm_clk_i)
   begin
      if ((wbm_rsp_o.ack || wbm_rsp_o.err) && !wbm_req_i.stb)
      begin
         $display("response on the external port without an access");
         fail_cnt++;
      end
      if ((aux_rsp_o.ack || aux_rsp_o.err) && !aux_req_i.stb)
      begin
         $display("response on the auxiliary port without an access");
         fail_cnt++;
      end
   end

   task automatic load_cases;
      integer         fd;
      integer         rc;
      reg [8*24-1:0]  tok;
      reg [8*128-1:0] junk;
      begin
         fd = $fopen("tb/wbh_cases.txt", "r");
         if (fd == 0)
            $display("cannot open tb/wbh_cases.txt");
         else
         begin
            while (!$feof(fd) && n_cases < 64)
            begin
               tok = '0;
               rc  = $fscanf(fd, "%s", tok);
               if (rc == 1 && tok == "#")
                  rc = $fgets(junk, fd);     // legend line
               else if (rc == 1)
               begin
                  c_name[n_cases] = tok;
                  rc = $fscanf(fd, "%d %s %h %h %h", c_mst[n_cases], c_op[n_cases],
                               c_adr[n_cases], c_dat[n_cases], c_exp[n_cases]);
                  if (rc == 5)
                     n_cases++;
               end
            end
            $fclose(fd);
            if (n_cases == 0)
               $display("no test cases in tb/wbh_cases.txt");
         end
      end
   endtask

   // one wishbone access, stb held until ack or err
   task automatic run_access(input int m, input logic we, input logic [31:0] adr,
                             input logic [31:0] dat, output logic [31:0] rdata,
                             output logic err, output logic done, output time t_end);
      wb_req_t r;
      wb_rsp_t rsp;
      int      n;
      begin
         r     = '0;
         r.cyc = 1'b1;
         r.stb = 1'b1;
         r.adr = adr;
         r.we  = we;
         r.dat = dat;
         r.sel = 4'hf;
         done  = 1'b0;
         rdata = '0;
         err   = 1'b0;
         t_end = 0;
         n     = 0;
         @(posedge wbm_clk_i);
         if (m == 0)
            wbm_req_i <= r;
         else
            aux_req_i <= r;
         while (!done && n < ACC_LIMIT)
         begin
            @(posedge wbm_clk_i);
            rsp = (m == 0) ? wbm_rsp_o : aux_rsp_o;
            if (rsp.ack || rsp.err)
            begin
               done  = 1'b1;
               rdata = rsp.dat;
               err   = rsp.err;
               t_end = $time;
            end
            n++;
         end
         if (m == 0)
            wbm_req_i <= '0;                 // stb drops at the ack edge
         else
            aux_req_i <= '0;
      end
   endtask

   task automatic run_case(input int i);
      logic [31:0] rd0;
      logic [31:0] rd1;
      logic        er0;
      logic        er1;
      logic        ok0;
      logic        ok1;
      time         t0;
      time         t1;
      logic [31:0] got;
      logic [31:0] expv;
      reg_idx_t    idx;
      string       why;
      begin
         why  = "";
         expv = c_exp[i];
         got  = expv;
         idx  = c_adr[i][`WBH_REG_ADR_MSB:`WBH_REG_ADR_LSB];
         if (c_mst[i] == 2)
         begin
            fork                             // aux takes the next word
               run_access(0, 1'b0, c_adr[i], '0, rd0, er0, ok0, t0);
               run_access(1, 1'b0, c_adr[i] + 4, '0, rd1, er1, ok1, t1);
            join
            if (!ok0 || !ok1)
               why = "no acknowledge from host";
            else if (er0 || er1)
               why = "unexpected error response";
            else if (t1 <= t0)
               why = "auxiliary master finished before external master";
            else if (rd0 != c_exp[i])
               got = rd0;
            else
            begin
               expv = c_dat[i];
               got  = rd1;
            end
         end
         else
         begin
            run_access(c_mst[i], c_op[i] == "w", c_adr[i], c_dat[i], rd0, er0, ok0, t0);
            if (!ok0)
               why = "no acknowledge from host";
            else if (c_op[i] == "e")
            begin
               if (!er0)
                  why = "access ended with ack instead of err";
            end
            else if (er0)
               why = "unexpected error response";
            else if (!c_adr[i][`WBH_LOCAL_BIT] && slv_we != (c_op[i] == "w"))
               why = "slave saw the wrong write enable";
            else if (c_op[i] == "r")
               got = rd0;
            else if (c_adr[i][`WBH_LOCAL_BIT])
            begin
               if (idx == `WBH_REG_BANK)
               begin
                  // bank has no output, read it back
                  run_access(c_mst[i], 1'b0, c_adr[i], '0, rd1, er1, ok1, t1);
                  if (!ok1 || er1)
                     why = "bank readback did not complete";
                  else
                     got = rd1;
               end
               else
                  got = (idx == `WBH_REG_GLB) ? {24'h0, subsys_rst_o} :
                        (idx == `WBH_REG_CLK1) ? cfg_clk_ctrl1_o : cfg_clk_ctrl2_o;
            end
            else if (slv_dat != c_dat[i] || slv_sel != 4'hf)
               why = "slave saw wrong write data or byte enables";
            else
               got = slv_adr;                // banked slave address
         end
         if (why != "")
         begin
            $display("%0s in test %0s", why, c_name[i]);
            fail_cnt++;
         end
         else if (got != expv)
         begin
            $display("FAILED %0s expected %h actual %h", c_name[i], expv, got);
            fail_cnt++;
         end
         else
         begin
            $display("ok     %0s", c_name[i]);
            pass_cnt++;
         end
      end
   endtask

   initial
   begin
      wbm_rst_n = 1'b0;
      wbm_req_i = '0;
      aux_req_i = '0;
      wbs_rsp_i = '0;
      load_cases();
      loaded = 1'b1;
      repeat (2) @(posedge wbm_clk_i);
      wbm_rst_n <= 1'b1;
      @(posedge wbm_clk_i);
      // subsystems held in reset, clock words cleared
      if (subsys_rst_o != '0 || cfg_clk_ctrl1_o != '0 || cfg_clk_ctrl2_o != '0)
      begin
         $display("FAILED reset_outputs expected 0 actual %h %h %h", subsys_rst_o,
                  cfg_clk_ctrl1_o, cfg_clk_ctrl2_o);
         fail_cnt++;
      end
      else
      begin
         $display("ok     reset_outputs");
         pass_cnt++;
      end
      for (int i = 0; i < n_cases; i++)
         run_case(i);
      repeat (4) @(posedge wbm_clk_i);
      $display("passed %0d failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && n_cases > 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

   // watchdog, 40 cycles per case plus margin
   initial
   begin
      wait (loaded);
      repeat ((n_cases + 2) * 40) @(posedge wbm_clk_i);
      $display("watchdog expired");
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

/* sim.f */
+incdir+logic
logic/wbh_bus_pkg.sv
logic/wbh_reg_pkg.sv
logic/wbh_arb.sv
logic/wbh_req_stage.sv
logic/wbh_regs.sv
logic/wb_host.sv
tb/tb_wb_host.sv

/* tb/wbh_cases.txt */
# name master(0 ext,1 aux,2 both) op(r,w,e=read ending in err) address data expected
# local write: expected output; remote write: slave address; both: aux reads address+4 expecting data
rst_glb   0 r 00800000 00000000 00000000
rst_bank  0 r 00800004 00000000 00000010
rst_clk1  0 r 00800008 00000000 00000000
rst_clk2  0 r 0080000c 00000000 00000000
wr_glb    0 w 00800000 a5c3e1a5 000000a5
wr_bank   0 w 00800004 12345633 00000033
wr_clk1   1 w 00800008 deadbeef deadbeef
wr_clk2   0 w 0080000c 0badf00d 0badf00d
rd_glb    0 r 00800000 00000000 a5c3e1a5
rd_bank   1 r 00800004 00000000 00000033
rd_clk1   0 r 00800008 00000000 deadbeef
rd_clk2   1 r 0080000c 00000000 0badf00d
rem_wr    0 w 00123458 cafe0001 33123458
both_loc  2 r 00800008 0badf00d deadbeef
aux_rem   1 r 00000abc 00000000 ccfff543
rem_rd    0 r 4a7f0010 00000000 cc80ffef
both_rem  2 r 00000100 ccfffefb ccfffeff
bank_ee   0 w 00800004 000000ee 000000ee
rem_err   1 e 00000200 00000000 00000000
ext_err   0 e 007f0000 00000000 00000000
